// File: verif/riscv_mul_patterns.txt
// columns: op rs1 rs2 expected, all hex
// op: 0 mulw, 4 mul, 5 mulh, 6 mulhu, 7 mulhsu
4 0000000000000003 0000000000000007 0000000000000015
4 ffffffffffffffff ffffffffffffffff 0000000000000001
5 ffffffffffffffff ffffffffffffffff 0000000000000000
6 ffffffffffffffff ffffffffffffffff fffffffffffffffe
7 ffffffffffffffff ffffffffffffffff ffffffffffffffff
4 8000000000000000 8000000000000000 0000000000000000
5 8000000000000000 8000000000000000 4000000000000000
6 8000000000000000 8000000000000000 4000000000000000
7 8000000000000000 8000000000000000 c000000000000000
5 8000000000000000 ffffffffffffffff 0000000000000000
4 8000000000000000 ffffffffffffffff 8000000000000000
4 0000000000000000 123456789abcdef0 0000000000000000
5 7fffffffffffffff 7fffffffffffffff 3fffffffffffffff
6 0000000100000000 0000000100000000 0000000000000001
7 0000000000000002 ffffffffffffffff 0000000000000001
5 ffffffffffffffff 0000000000000002 ffffffffffffffff
6 0000000000000000 ffffffffffffffff 0000000000000000
7 8000000000000000 0000000000000000 0000000000000000
0 ffffffff00000003 1234567800000005 000000000000000f
0 deadbeef40000000 0000000100000002 ffffffff80000000
0 ffffffffffffffff ffffffffffffffff 0000000000000001
0 00000000ffffffff 0000000000000002 fffffffffffffffe
0 0000000012345678 0000000000000010 0000000023456780

// File: src.f
+incdir+include
design/riscv_mul_pkg.sv
design/riscv_mul_operand_prep.sv
design/riscv_mul_booth_datapath.sv
design/riscv_mul_result_sel.sv
design/riscv_mul_ctrl.sv
design/riscv_mul_top.sv
verif/riscv_mul_asserts.sv
verif/riscv_mul_tb.sv

// File: Makefile
# Verilator build and run for the RV64 multiply unit
# override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= riscv_mul_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SOURCES  := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation FAILED, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/riscv_mul_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_tb;

  localparam int clk_period  = 4;
  localparam int rst_cycles  = 4;
  localparam int rand_ops    = 200;
  localparam int op_budget   = 80;   // cycles per operation incl. back-pressure
  localparam int ack_latency = 66;
  localparam int ack_timeout = 200;
  localparam int max_extra   = 10;

  logic                       clk;
  logic                       rst;
  logic                       req;
  riscv_mul_pkg::mul_op_e     op;
  logic [`RISCV_MUL_XLEN-1:0] rs1;
  logic [`RISCV_MUL_XLEN-1:0] rs2;
  logic                       ack;
  logic [`RISCV_MUL_XLEN-1:0] product;

  riscv_mul_pkg::mul_op_e     pat_op [$];
  logic [`RISCV_MUL_XLEN-1:0] pat_rs1 [$];
  logic [`RISCV_MUL_XLEN-1:0] pat_rs2 [$];
  logic [`RISCV_MUL_XLEN-1:0] pat_exp [$];
  int                         num_patterns = 0;
  logic                       patterns_loaded = 1'b0;
  logic                       fail_printed = 1'b0;
  logic                       run_passed = 1'b0;

  riscv_mul_top riscv_mul_top_i (
    .i_riscv_mul_clk     (clk),
    .i_riscv_mul_rst     (rst),
    .i_riscv_mul_req     (req),
    .i_riscv_mul_op      (op),
    .i_riscv_mul_rs1data (rs1),
    .i_riscv_mul_rs2data (rs2),
    .o_riscv_mul_ack     (ack),
    .o_riscv_mul_product (product)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic void report_failure();
    if (!fail_printed)
    begin
      fail_printed = 1'b1;
      $display("Done: errors found");
    end
  endfunction

  task automatic check_value(input string what, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected)
    begin
      $display("** Error @ %0t: %s: got 0x%h, expected 0x%h", $time, what, actual, expected);
      report_failure();
      $fatal(1, "check failed");
    end
  endtask

  // exact product of the extended operands, then the slice the opcode asks for
  function automatic logic [63:0] model_product(input riscv_mul_pkg::mul_op_e m_op,
                                                input logic [63:0] a, input logic [63:0] b);
    logic [127:0] a_wide;
    logic [127:0] b_wide;
    logic [127:0] full;
    logic [31:0]  word;
    a_wide = {{64{a[63]}}, a};
    b_wide = {{64{b[63]}}, b};
    if (m_op == riscv_mul_pkg::OP_MULHU)
    begin
      a_wide = {64'b0, a};
      b_wide = {64'b0, b};
    end
    else if (m_op == riscv_mul_pkg::OP_MULHSU)
      b_wide = {64'b0, b};  // rs2 unsigned
    full = a_wide * b_wide;
    word = a[31:0] * b[31:0];
    case (m_op)
      riscv_mul_pkg::OP_MUL:  model_product = full[63:0];
      riscv_mul_pkg::OP_MULW: model_product = {{32{word[31]}}, word};
      default:                model_product = full[127:64];
    endcase
  endfunction

  function automatic riscv_mul_pkg::mul_op_e random_op();
    case ($urandom % 5)
      0:       random_op = riscv_mul_pkg::OP_MULW;
      1:       random_op = riscv_mul_pkg::OP_MUL;
      2:       random_op = riscv_mul_pkg::OP_MULH;
      3:       random_op = riscv_mul_pkg::OP_MULHU;
      default: random_op = riscv_mul_pkg::OP_MULHSU;
    endcase
  endfunction

  task automatic load_patterns();
    int         fd;
    int         fields;
    string      line;
    logic [3:0] f_op;
    logic [63:0] f_a;
    logic [63:0] f_b;
    logic [63:0] f_exp;
    fd = $fopen("verif/riscv_mul_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the pattern file verif/riscv_mul_patterns.txt");
      report_failure();
      $fatal(1, "missing stimulus file");
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() < 2 || line.substr(0, 1) == "//")
          continue;  // blank or comment
        fields = $sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp);
        if (fields == 4)
        begin
          pat_op.push_back(riscv_mul_pkg::mul_op_e'(f_op[2:0]));
          pat_rs1.push_back(f_a);
          pat_rs2.push_back(f_b);
          pat_exp.push_back(f_exp);
        end
      end
      $fclose(fd);
      num_patterns = pat_op.size();
    end
  endtask

  // one four-phase handshake with a random back-pressure tail
  task automatic run_operation(input riscv_mul_pkg::mul_op_e t_op, input logic [63:0] a,
                               input logic [63:0] b, input logic [63:0] exp,
                               input string tag);
    int          edges;
    int          extra;
    logic [63:0] held;
    @(posedge clk);
    req <= 1'b1;
    op  <= t_op;
    rs1 <= a;
    rs2 <= b;
    edges = -1;
    do
    begin
      @(posedge clk);
      edges++;
      @(negedge clk);
    end while (!ack && edges < ack_timeout);
    check_value({tag, " ack arrived"}, 64'(ack), 64'd1);
    check_value({tag, " ack latency"}, 64'(edges), 64'(ack_latency));
    check_value({tag, " product"}, product, exp);
    held  = product;
    extra = $urandom_range(max_extra, 0);
    repeat (extra)
    begin
      @(posedge clk);
      @(negedge clk);
      check_value({tag, " ack held"}, 64'(ack), 64'd1);
      check_value({tag, " product held"}, product, held);
    end
    @(posedge clk);
    req <= 1'b0;
    @(negedge clk);
    check_value({tag, " ack before release"}, 64'(ack), 64'd1);
    @(posedge clk);
    @(negedge clk);
    check_value({tag, " ack released"}, 64'(ack), 64'd0);
    check_value({tag, " product after release"}, product, held);
  endtask

  initial
  begin
    riscv_mul_pkg::mul_op_e r_op;
    logic [63:0]            r_a;
    logic [63:0]            r_b;
    rst = 1'b1;
    req = 1'b0;
    op  = riscv_mul_pkg::OP_MUL;
    rs1 = '0;
    rs2 = '0;
    void'($urandom(32'h88e2));
    load_patterns();
    patterns_loaded = 1'b1;
    if (num_patterns == 0)
    begin
      $display("the pattern file holds no usable lines");
      report_failure();
      $fatal(1, "empty stimulus file");
    end
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("ack after reset", 64'(ack), 64'd0);
    check_value("product after reset", product, 64'd0);
    for (int i = 0; i < num_patterns; i++)
      run_operation(pat_op[i], pat_rs1[i], pat_rs2[i], pat_exp[i],
                    $sformatf("pattern %0d", i));
    for (int i = 0; i < rand_ops; i++)
    begin
      r_op = random_op();
      r_a  = {$urandom, $urandom};
      r_b  = {$urandom, $urandom};
      run_operation(r_op, r_a, r_b, model_product(r_op, r_a, r_b),
                    $sformatf("random %0d", i));
    end
    if (riscv_mul_top_i.riscv_mul_asserts_i.fail_count == 0)
    begin
      run_passed = 1'b1;
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("%0d assertion failures during the run",
               riscv_mul_top_i.riscv_mul_asserts_i.fail_count);
      report_failure();
      $fatal(1, "assertion failures");
    end
  end

  // budget scales with the number of operations
  initial
  begin
    longint limit_ns;
    wait (patterns_loaded);
    limit_ns = longint'(num_patterns + rand_ops) * op_budget * clk_period
               + (rst_cycles + 2) * clk_period;
    #(limit_ns);
    $display("timeout: the tests did not finish within %0d ns", limit_ns);
    report_failure();
    $fatal(1, "watchdog expired");
  end

  final
  begin
    if (!run_passed)
      report_failure();  // run stopped by a failed assertion
  end

endmodule

`default_nettype wire

// File: verif/riscv_mul_asserts.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_asserts (
  input logic                       i_riscv_mul_clk,
  input logic                       i_riscv_mul_rst,
  input logic                       i_riscv_mul_req,
  input logic                       i_riscv_mul_ack,
  input riscv_mul_pkg::mul_op_e     i_riscv_mul_op,
  input logic [`RISCV_MUL_XLEN-1:0] i_riscv_mul_rs1data,
  input logic [`RISCV_MUL_XLEN-1:0] i_riscv_mul_rs2data,
  input logic                       i_riscv_mul_load,
  input logic                       i_riscv_mul_step,
  input logic                       i_riscv_mul_capture
);

  int unsigned fail_count = 0;

  ack_needs_req: assert property (@(posedge i_riscv_mul_clk) disable iff (i_riscv_mul_rst)
    $rose(i_riscv_mul_ack) |-> $past(i_riscv_mul_req))
  else
  begin
    fail_count++;
    $error("ack rose without a pending req");
  end

  ack_held: assert property (@(posedge i_riscv_mul_clk) disable iff (i_riscv_mul_rst)
    (i_riscv_mul_ack && i_riscv_mul_req) |=> i_riscv_mul_ack)
  else
  begin
    fail_count++;
    $error("ack dropped while req still high");
  end

  // requester side of the handshake
  inputs_stable: assert property (@(posedge i_riscv_mul_clk) disable iff (i_riscv_mul_rst)
    (i_riscv_mul_req && !i_riscv_mul_ack) |=> ($stable(i_riscv_mul_op)
      && $stable(i_riscv_mul_rs1data) && $stable(i_riscv_mul_rs2data)))
  else
  begin
    fail_count++;
    $error("op or operands changed during an operation");
  end

  // capture one cycle after the last of the booth steps
  load_to_capture: assert property (@(posedge i_riscv_mul_clk) disable iff (i_riscv_mul_rst)
    i_riscv_mul_capture |-> ($past(i_riscv_mul_load, `RISCV_MUL_STEPS + 1)
      && $past(i_riscv_mul_step)))
  else
  begin
    fail_count++;
    $error("capture did not follow load by the full step count");
  end

endmodule

bind riscv_mul_top riscv_mul_asserts riscv_mul_asserts_i (
  .i_riscv_mul_clk     (i_riscv_mul_clk),
  .i_riscv_mul_rst     (i_riscv_mul_rst),
  .i_riscv_mul_req     (i_riscv_mul_req),
  .i_riscv_mul_ack     (o_riscv_mul_ack),
  .i_riscv_mul_op      (i_riscv_mul_op),
  .i_riscv_mul_rs1data (i_riscv_mul_rs1data),
  .i_riscv_mul_rs2data (i_riscv_mul_rs2data),
  .i_riscv_mul_load    (load),
  .i_riscv_mul_step    (step),
  .i_riscv_mul_capture (capture)
);

`default_nettype wire

// File: design/riscv_mul_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_top (
  input  logic                        i_riscv_mul_clk,
  input  logic                        i_riscv_mul_rst,
  input  logic                        i_riscv_mul_req,
  input  riscv_mul_pkg::mul_op_e      i_riscv_mul_op,
  input  logic [`RISCV_MUL_XLEN-1:0]  i_riscv_mul_rs1data,
  input  logic [`RISCV_MUL_XLEN-1:0]  i_riscv_mul_rs2data,
  output logic                        o_riscv_mul_ack,
  output logic [`RISCV_MUL_XLEN-1:0]  o_riscv_mul_product
);

  logic                               load;
  logic                               step;
  logic                               capture;
  logic signed [`RISCV_MUL_EXT_W-1:0] mcand;
  logic signed [`RISCV_MUL_EXT_W-1:0] mplier;
  logic signed [`RISCV_MUL_ACC_W-1:0] acc;

  riscv_mul_ctrl riscv_mul_ctrl_i (
    .i_riscv_mul_clk     (i_riscv_mul_clk),
    .i_riscv_mul_rst     (i_riscv_mul_rst),
    .i_riscv_mul_req     (i_riscv_mul_req),
    .o_riscv_mul_load    (load),
    .o_riscv_mul_step    (step),
    .o_riscv_mul_capture (capture),
    .o_riscv_mul_ack     (o_riscv_mul_ack)
  );

  riscv_mul_operand_prep riscv_mul_operand_prep_i (
    .i_riscv_mul_op      (i_riscv_mul_op),
    .i_riscv_mul_rs1data (i_riscv_mul_rs1data),
    .i_riscv_mul_rs2data (i_riscv_mul_rs2data),
    .o_riscv_mul_mcand   (mcand),
    .o_riscv_mul_mplier  (mplier)
  );

  riscv_mul_booth_datapath riscv_mul_booth_datapath_i (
    .i_riscv_mul_clk    (i_riscv_mul_clk),
    .i_riscv_mul_rst    (i_riscv_mul_rst),
    .i_riscv_mul_load   (load),
    .i_riscv_mul_step   (step),
    .i_riscv_mul_mcand  (mcand),
    .i_riscv_mul_mplier (mplier),
    .o_riscv_mul_acc    (acc)
  );

  riscv_mul_result_sel riscv_mul_result_sel_i (
    .i_riscv_mul_clk     (i_riscv_mul_clk),
    .i_riscv_mul_rst     (i_riscv_mul_rst),
    .i_riscv_mul_capture (capture),
    .i_riscv_mul_op      (i_riscv_mul_op),  // held by requester until ack
    .i_riscv_mul_acc     (acc),
    .o_riscv_mul_product (o_riscv_mul_product)
  );

endmodule

`default_nettype wire

// File: design/riscv_mul_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_ctrl (
  input  logic i_riscv_mul_clk,
  input  logic i_riscv_mul_rst,
  input  logic i_riscv_mul_req,
  output logic o_riscv_mul_load,
  output logic o_riscv_mul_step,
  output logic o_riscv_mul_capture,
  output logic o_riscv_mul_ack
);

  localparam int cnt_w = `RISCV_MUL_CNT_W;
  localparam logic [cnt_w-1:0] num_steps = cnt_w'(`RISCV_MUL_STEPS);

  riscv_mul_pkg::mul_state_e state;
  riscv_mul_pkg::mul_state_e next_state;
  logic [cnt_w-1:0]          step_cnt;  // steps done so far
  logic                      release_ack;

  assign o_riscv_mul_load    = (state == riscv_mul_pkg::ST_IDLE) && i_riscv_mul_req;
  assign o_riscv_mul_step    = (state == riscv_mul_pkg::ST_BUSY) && (step_cnt != num_steps);
  assign o_riscv_mul_capture = (state == riscv_mul_pkg::ST_BUSY) && (step_cnt == num_steps);
  assign release_ack         = (state == riscv_mul_pkg::ST_DONE) && !i_riscv_mul_req;

  always_comb
  begin
    next_state = state;
    case (state)
      riscv_mul_pkg::ST_IDLE:
        if (i_riscv_mul_req)
          next_state = riscv_mul_pkg::ST_BUSY;
      riscv_mul_pkg::ST_BUSY:
        if (o_riscv_mul_capture)
          next_state = riscv_mul_pkg::ST_DONE;
      riscv_mul_pkg::ST_DONE:
        if (!i_riscv_mul_req)
          next_state = riscv_mul_pkg::ST_IDLE;  // four-phase return
      default:
        next_state = riscv_mul_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
    begin
      state    <= riscv_mul_pkg::ST_IDLE;
      step_cnt <= '0;
    end
    else
    begin
      state <= next_state;
      if (o_riscv_mul_load)
        step_cnt <= '0;
      else if (o_riscv_mul_step)
        step_cnt <= step_cnt + 1'b1;
    end
  end

  // ack rises with the captured product, falls once req is gone
  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
      o_riscv_mul_ack <= 1'b0;
    else if (o_riscv_mul_capture)
      o_riscv_mul_ack <= 1'b1;
    else if (release_ack)
      o_riscv_mul_ack <= 1'b0;
  end

endmodule

`default_nettype wire

// File: design/riscv_mul_result_sel.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_result_sel (
  input  logic                                i_riscv_mul_clk,
  input  logic                                i_riscv_mul_rst,
  input  logic                                i_riscv_mul_capture,
  input  riscv_mul_pkg::mul_op_e              i_riscv_mul_op,
  input  logic signed [`RISCV_MUL_ACC_W-1:0]  i_riscv_mul_acc,
  output logic [`RISCV_MUL_XLEN-1:0]          o_riscv_mul_product
);

  localparam int xlen   = `RISCV_MUL_XLEN;
  localparam int word_w = 32;

  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
    begin
      o_riscv_mul_product <= '0;
    end
    else if (i_riscv_mul_capture)
    begin
      case (i_riscv_mul_op)
        riscv_mul_pkg::OP_MUL:
          o_riscv_mul_product <= i_riscv_mul_acc[xlen-1:0];
        riscv_mul_pkg::OP_MULH,
        riscv_mul_pkg::OP_MULHU,
        riscv_mul_pkg::OP_MULHSU:
          o_riscv_mul_product <= i_riscv_mul_acc[2*xlen-1:xlen];  // high half
        riscv_mul_pkg::OP_MULW:
          o_riscv_mul_product <= {{(xlen-word_w){i_riscv_mul_acc[word_w-1]}},
                                  i_riscv_mul_acc[word_w-1:0]};
        default:
          o_riscv_mul_product <= '0;  // unused encodings
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/riscv_mul_booth_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_booth_datapath (
  input  logic                                i_riscv_mul_clk,
  input  logic                                i_riscv_mul_rst,
  input  logic                                i_riscv_mul_load,
  input  logic                                i_riscv_mul_step,
  input  logic signed [`RISCV_MUL_EXT_W-1:0]  i_riscv_mul_mcand,
  input  logic signed [`RISCV_MUL_EXT_W-1:0]  i_riscv_mul_mplier,
  output logic signed [`RISCV_MUL_ACC_W-1:0]  o_riscv_mul_acc
);

  localparam int ext_w = `RISCV_MUL_EXT_W;
  localparam int acc_w = `RISCV_MUL_ACC_W;

  logic signed [ext_w-1:0] mcand_q;
  logic signed [acc_w-1:0] acc_q;
  logic                    prev_bit;   // q[-1]
  logic        [ext_w:0]   upper_ext;  // upper half plus guard bit
  logic        [ext_w:0]   mcand_ext;
  logic        [ext_w:0]   partial;

  // the guard bit keeps the true sign through the add, so the shift
  // brings in the right bit even if the 65-bit sum would wrap
  assign upper_ext = {acc_q[acc_w-1], acc_q[acc_w-1:ext_w]};
  assign mcand_ext = {mcand_q[ext_w-1], mcand_q};

  always_comb
  begin
    case ({acc_q[0], prev_bit})
      2'b10:   partial = upper_ext - mcand_ext;  // start of a run of ones
      2'b01:   partial = upper_ext + mcand_ext;  // end of a run
      default: partial = upper_ext;
    endcase
  end

  always_ff @(posedge i_riscv_mul_clk or posedge i_riscv_mul_rst)
  begin
    if (i_riscv_mul_rst)
    begin
      acc_q    <= '0;
      mcand_q  <= '0;
      prev_bit <= 1'b0;
    end
    else if (i_riscv_mul_load)
    begin
      acc_q    <= {{ext_w{1'b0}}, i_riscv_mul_mplier};
      mcand_q  <= i_riscv_mul_mcand;
      prev_bit <= 1'b0;
    end
    else if (i_riscv_mul_step)
    begin
      acc_q    <= {partial, acc_q[ext_w-1:1]};  // add then arithmetic shift
      prev_bit <= acc_q[0];
    end
  end

  assign o_riscv_mul_acc = acc_q;

endmodule

`default_nettype wire

// File: design/riscv_mul_operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

`include "riscv_mul_params.svh"

module riscv_mul_operand_prep (
  input  riscv_mul_pkg::mul_op_e              i_riscv_mul_op,
  input  logic [`RISCV_MUL_XLEN-1:0]          i_riscv_mul_rs1data,
  input  logic [`RISCV_MUL_XLEN-1:0]          i_riscv_mul_rs2data,
  output logic signed [`RISCV_MUL_EXT_W-1:0]  o_riscv_mul_mcand,
  output logic signed [`RISCV_MUL_EXT_W-1:0]  o_riscv_mul_mplier
);

  localparam int xlen   = `RISCV_MUL_XLEN;
  localparam int ext_w  = `RISCV_MUL_EXT_W;
  localparam int word_w = 32;

  always_comb
  begin
    case (i_riscv_mul_op)
      riscv_mul_pkg::OP_MULHU:
      begin
        o_riscv_mul_mcand  = {1'b0, i_riscv_mul_rs1data};
        o_riscv_mul_mplier = {1'b0, i_riscv_mul_rs2data};
      end
      riscv_mul_pkg::OP_MULHSU:
      begin
        o_riscv_mul_mcand  = {i_riscv_mul_rs1data[xlen-1], i_riscv_mul_rs1data};
        o_riscv_mul_mplier = {1'b0, i_riscv_mul_rs2data};  // rs2 unsigned
      end
      riscv_mul_pkg::OP_MULW:
      begin
        // upper operand bits ignored, only low word of product kept
        o_riscv_mul_mcand  = {{(ext_w-word_w){1'b0}}, i_riscv_mul_rs1data[word_w-1:0]};
        o_riscv_mul_mplier = {{(ext_w-word_w){1'b0}}, i_riscv_mul_rs2data[word_w-1:0]};
      end
      default:
      begin
        o_riscv_mul_mcand  = {i_riscv_mul_rs1data[xlen-1], i_riscv_mul_rs1data};  // mul, mulh
        o_riscv_mul_mplier = {i_riscv_mul_rs2data[xlen-1], i_riscv_mul_rs2data};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/riscv_mul_pkg.sv
`default_nettype none

package riscv_mul_pkg;

  // low three bits of the M-extension multiply control field
  typedef enum logic [2:0] {
    OP_MULW   = 3'b000,
    OP_MUL    = 3'b100,
    OP_MULH   = 3'b101,
    OP_MULHU  = 3'b110,
    OP_MULHSU = 3'b111
  } mul_op_e;

  // sequencer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,  // waiting for req
    ST_BUSY = 2'b01,  // booth steps, then capture
    ST_DONE = 2'b10   // ack high until req drops
  } mul_state_e;

endpackage

`default_nettype wire

// File: include/riscv_mul_params.svh
`ifndef RISCV_MUL_PARAMS_SVH
`define RISCV_MUL_PARAMS_SVH

// register width of the RV64 integer datapath
`define RISCV_MUL_XLEN 64

// one extra bit so unsigned operands stay positive in signed Booth
`define RISCV_MUL_EXT_W 65

// accumulator holds {partial sum, multiplier}
`define RISCV_MUL_ACC_W 130

// one add/shift per extended multiplier bit
`define RISCV_MUL_STEPS 65

// wide enough to count to RISCV_MUL_STEPS
`define RISCV_MUL_CNT_W 7

`endif
